// File: list.f
+incdir+sim
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/alu.sv
hdl/fetch_unit.sv
hdl/instruction_decoder.sv
hdl/datapath.sv
hdl/ram_port.sv
hdl/cpu_core.sv
sim/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpu_tb -f list.f \
    && ./obj_dir/Vcpu_tb | tee sim.log
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// wrong values and other failures are counted apart
int value_errors = 0;
int other_errors = 0;

task automatic check_nibble(string name, isa_pkg::nibble_t got, isa_pkg::nibble_t want);
    if (got !== want) begin
        value_errors++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
    end
endtask

task automatic check_addr(string name, logic [7:0] got, logic [7:0] want);
    if (got !== want) begin
        value_errors++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
    end
endtask

task automatic check_pc(string name, isa_pkg::pc_t got, isa_pkg::pc_t want);
    if (got !== want) begin
        value_errors++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
    end
endtask

task automatic report_problem(string msg);
    other_errors++;
    $display("ERROR: %s at %0t", msg, $time);
endtask

task automatic print_counts();
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
endtask

`endif

// File: sim/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

    localparam int NUM_ROWS = 57;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 16 + 100;

    typedef struct packed {
        logic [7:0]       word;
        logic             has_exp;
        logic [7:0]       exp_addr;
        isa_pkg::nibble_t exp_data;
    } row_t;

    // one program word per row from address 0
    localparam logic [7:0] PROGRAM_WORDS [NUM_ROWS] = '{
        // LDM 5, WRM
        8'hd5, 8'he0,
        // FIM P1 3C, SRC P1, WRM, INC R3, LD R3, WRM
        8'h22, 8'h3c, 8'h23, 8'he0, 8'h63, 8'ha3, 8'he0,
        // SRC P1, WRM, XCH R2, WRM, SRC P1, WRM
        8'h23, 8'he0, 8'hb2, 8'he0, 8'h23, 8'he0,
        // ADD R3, WRM, TCC, WRM, SUB R2, WRM, TCC, WRM
        8'h83, 8'he0, 8'hf7, 8'he0, 8'h92, 8'he0, 8'hf7, 8'he0,
        // LDM F, IAC, WRM, TCC, WRM, DAC, WRM, TCC, WRM
        8'hdf, 8'hf2, 8'he0, 8'hf7, 8'he0, 8'hf8, 8'he0, 8'hf7, 8'he0,
        // STC, RAL, WRM, CMA, WRM, CMC, RAR, WRM
        8'hfa, 8'hf5, 8'he0, 8'hf4, 8'he0, 8'hf3, 8'hf6, 8'he0,
        // RAL, TCC, WRM, CLB, WRM, STC, CLC, TCC, WRM
        8'hf5, 8'hf7, 8'he0, 8'hf0, 8'he0, 8'hfa, 8'hf1, 8'hf7, 8'he0,
        // JUN 035 over a poisoned LDM 9 and WRM
        8'h40, 8'h35, 8'hd9, 8'he0,
        // LDM 6, WRM, then JUN to itself
        8'hd6, 8'he0, 8'h40, 8'h37
    };

    logic clock;
    logic reset;
    isa_pkg::nibble_t data;
    isa_pkg::pc_t rom_addr;
    logic sync;
    logic [7:0] out_addr;
    isa_pkg::nibble_t out_data;
    logic out_strobe;

    row_t prog_table [NUM_ROWS];
    logic [7:0] rom [4096];
    isa_pkg::pc_t pc_seq [$];
    isa_pkg::phase_t mem_phase;
    int strobe_count;
    int expected_strobes;
    int cycle_count;

    `include "tb_checks.svh"

    cpu_core dut_i (
        .clock      (clock),
        .reset      (reset),
        .data       (data),
        .rom_addr   (rom_addr),
        .sync       (sync),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .out_strobe (out_strobe)
    );

    function automatic isa_pkg::nibble_t rom_nibble(isa_pkg::phase_t ph, isa_pkg::pc_t addr);
        logic [7:0] word;
        word = rom[addr];
        if (ph == isa_pkg::PH_FETCH_HI) begin
            return word[7:4];
        end
        if (ph == isa_pkg::PH_FETCH_LO) begin
            return word[3:0];
        end
        return 4'h0;
    endfunction

    task automatic load_program();
        // unused space differs with every address bit
        for (int a = 0; a < 4096; a++) begin
            rom[a] = 8'(a ^ (a >> 4) ^ (a >> 8));
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            prog_table[i].word = PROGRAM_WORDS[i];
            prog_table[i].has_exp = 1'b0;
            prog_table[i].exp_addr = 8'h00;
            prog_table[i].exp_data = 4'h0;
            rom[i] = prog_table[i].word;
        end
    endtask

    // ISA reference model that follows the program counter until a jump to itself
    task automatic run_model();
        isa_pkg::nibble_t regs [isa_pkg::NUM_REGS];
        isa_pkg::nibble_t acc;
        isa_pkg::nibble_t tmp;
        logic carry;
        logic [7:0] ram_addr;
        logic [7:0] op;
        logic [7:0] arg;
        logic [3:0] r;
        isa_pkg::pc_t pc;
        isa_pkg::pc_t next_pc;
        logic halted;
        int steps;
        int row;
        for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
            regs[i] = 4'h0;
        end
        acc = 4'h0;
        carry = 1'b0;
        ram_addr = 8'h00;
        pc = 12'h000;
        halted = 1'b0;
        steps = 0;
        expected_strobes = 0;
        while (!halted && steps < 4 * NUM_ROWS) begin
            op = rom[pc];
            arg = rom[pc + 12'd1];
            r = op[3:0];
            row = int'(pc);
            pc_seq.push_back(pc);
            steps++;
            next_pc = pc + 12'd1;
            case (isa_pkg::opcode_t'(op[7:4]))
                isa_pkg::OP_FIM_SRC: begin
                    if (op[0]) begin
                        ram_addr = {regs[{op[3:1], 1'b0}], regs[{op[3:1], 1'b1}]};
                    end else begin
                        regs[{op[3:1], 1'b0}] = arg[7:4];
                        regs[{op[3:1], 1'b1}] = arg[3:0];
                        pc_seq.push_back(next_pc);
                        next_pc = pc + 12'd2;
                    end
                end
                isa_pkg::OP_JUN: begin
                    pc_seq.push_back(next_pc);
                    next_pc = {op[3:0], arg};
                    halted = (next_pc == pc);
                end
                isa_pkg::OP_INC: regs[r] = regs[r] + 4'd1;
                isa_pkg::OP_ADD: {carry, acc} = {1'b0, acc} + {1'b0, regs[r]} + {4'b0000, carry};
                // carry set means no borrow
                isa_pkg::OP_SUB: {carry, acc} = {1'b0, acc} + {1'b0, ~regs[r]} + {4'b0000, ~carry};
                isa_pkg::OP_LD: acc = regs[r];
                isa_pkg::OP_XCH: begin
                    tmp = acc;
                    acc = regs[r];
                    regs[r] = tmp;
                end
                isa_pkg::OP_LDM: acc = r;
                isa_pkg::OP_IO: begin
                    if (r == isa_pkg::IO_WRM && row < NUM_ROWS) begin
                        prog_table[row].has_exp = 1'b1;
                        prog_table[row].exp_addr = ram_addr;
                        prog_table[row].exp_data = acc;
                        expected_strobes++;
                    end
                end
                isa_pkg::OP_ACC_GRP: begin
                    case (isa_pkg::acc_sub_t'(r))
                        isa_pkg::CLB: begin
                            acc = 4'h0;
                            carry = 1'b0;
                        end
                        isa_pkg::CLC: carry = 1'b0;
                        isa_pkg::IAC: {carry, acc} = {1'b0, acc} + 5'd1;
                        isa_pkg::CMC: carry = ~carry;
                        isa_pkg::CMA: acc = ~acc;
                        isa_pkg::RAL: {carry, acc} = {acc, carry};
                        isa_pkg::RAR: {acc, carry} = {carry, acc};
                        isa_pkg::TCC: begin
                            acc = {3'b000, carry};
                            carry = 1'b0;
                        end
                        isa_pkg::DAC: {carry, acc} = {1'b0, acc} + 5'd15;
                        isa_pkg::STC: carry = 1'b1;
                        default: begin
                        end
                    endcase
                end
                default: begin
                end
            endcase
            // the self jump fetches its target once more
            if (halted) begin
                pc_seq.push_back(next_pc);
            end
            pc = next_pc;
        end
    endtask

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // reset, program memory and per-cycle monitors
    initial begin
        reset = 1'b1;
        data = 4'h0;
        mem_phase = isa_pkg::PH_ADDR0;
        strobe_count = 0;
        load_program();
        run_model();
        repeat (5) begin
            @(posedge clock);
        end
        #1;
        reset = 1'b0;
        if (out_strobe !== 1'b0) begin
            report_problem("out_strobe is not low after reset");
        end
        forever begin
            if (mem_phase == isa_pkg::PH_ADDR0 && pc_seq.size() > 0) begin
                check_pc("rom_addr", rom_addr, pc_seq.pop_front());
            end
            data = rom_nibble(mem_phase, rom_addr);
            @(posedge clock);
            #1;
            mem_phase = isa_pkg::phase_t'(mem_phase + 3'd1);
            if (out_strobe) begin
                strobe_count++;
            end
            if (sync !== (mem_phase != isa_pkg::PH_X3)) begin
                report_problem("sync does not mark the last phase of the machine cycle");
            end
        end
    end

    // one memory write per expected row in program order
    initial begin
        @(negedge reset);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (prog_table[i].has_exp) begin
                @(posedge clock);
                #2;
                while (!out_strobe) begin
                    @(posedge clock);
                    #2;
                end
                check_addr("out_addr", out_addr, prog_table[i].exp_addr);
                check_nibble("out_data", out_data, prog_table[i].exp_data);
            end
        end
        while (pc_seq.size() > 0) begin
            @(posedge clock);
        end
        @(posedge clock);
        #2;
        if (strobe_count != expected_strobes) begin
            report_problem($sformatf("saw %0d memory writes but expected %0d",
                                     strobe_count, expected_strobes));
        end
        print_counts();
        if (value_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        report_problem($sformatf("timeout, program not finished after %0d cycles",
                                 TIMEOUT_CYCLES));
        print_counts();
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/1ns

module cpu_core #(
    parameter isa_pkg::pc_t RESET_PC = '0
) (
    input  logic             clock,
    input  logic             reset,
    input  isa_pkg::nibble_t data,
    output isa_pkg::pc_t     rom_addr,
    output logic             sync,
    output logic [7:0]       out_addr,
    output isa_pkg::nibble_t out_data,
    output logic             out_strobe
);

    isa_pkg::phase_t phase;
    logic [7:0] inst;
    logic second_word;
    logic pc_write;
    logic write_acc;
    logic clear_acc;
    logic write_carry;
    logic clear_carry;
    logic write_reg;
    ctrl_pkg::alu_op_t alu_op;
    ctrl_pkg::alu_in0_t alu_in0;
    ctrl_pkg::alu_in1_t alu_in1;
    ctrl_pkg::alu_cin_t alu_cin;
    ctrl_pkg::acc_in_t acc_in;
    ctrl_pkg::reg_in_t reg_in;
    logic [3:0] reg_index;
    logic addr_load;
    logic wrm;
    isa_pkg::nibble_t acc;
    logic [7:0] pair_value;

    // second_data feeds the jump target inside fetch only
    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .clock       (clock),
        .reset       (reset),
        .data        (data),
        .pc_write    (pc_write),
        .rom_addr    (rom_addr),
        .sync        (sync),
        .phase       (phase),
        .inst        (inst),
        .second_word (second_word),
        .second_data ()
    );

    instruction_decoder decoder_i (
        .inst        (inst),
        .phase       (phase),
        .second_word (second_word),
        .pc_write    (pc_write),
        .write_acc   (write_acc),
        .clear_acc   (clear_acc),
        .write_carry (write_carry),
        .clear_carry (clear_carry),
        .write_reg   (write_reg),
        .alu_op      (alu_op),
        .alu_in0     (alu_in0),
        .alu_in1     (alu_in1),
        .alu_cin     (alu_cin),
        .acc_in      (acc_in),
        .reg_in      (reg_in),
        .reg_index   (reg_index),
        .addr_load   (addr_load),
        .wrm         (wrm)
    );

    datapath datapath_i (
        .clock       (clock),
        .reset       (reset),
        .write_acc   (write_acc),
        .clear_acc   (clear_acc),
        .write_carry (write_carry),
        .clear_carry (clear_carry),
        .write_reg   (write_reg),
        .alu_op      (alu_op),
        .alu_in0     (alu_in0),
        .alu_in1     (alu_in1),
        .alu_cin     (alu_cin),
        .acc_in      (acc_in),
        .reg_in      (reg_in),
        .reg_index   (reg_index),
        .imm         (inst[3:0]),
        .data        (data),
        .acc         (acc),
        .pair_value  (pair_value)
    );

    ram_port ram_port_i (
        .clock      (clock),
        .reset      (reset),
        .addr_load  (addr_load),
        .wrm        (wrm),
        .pair_value (pair_value),
        .acc        (acc),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .out_strobe (out_strobe)
    );

endmodule

// File: hdl/ram_port.sv
`timescale 1ns/1ns

module ram_port (
    input  logic             clock,
    input  logic             reset,
    input  logic             addr_load,
    input  logic             wrm,
    input  logic [7:0]       pair_value,
    input  isa_pkg::nibble_t acc,
    output logic [7:0]       out_addr,
    output isa_pkg::nibble_t out_data,
    output logic             out_strobe
);

    always_ff @(posedge clock) begin
        if (reset) begin
            out_addr <= 8'h00;
            out_data <= '0;
            out_strobe <= 1'b0;
        end else begin
            // one clock pulse, the decoder holds wrm for a single phase
            out_strobe <= wrm;
            if (addr_load) begin
                out_addr <= pair_value;
            end
            if (wrm) begin
                out_data <= acc;
            end
        end
    end

    strobe_single_a: assert property (@(posedge clock) disable iff (reset)
        out_strobe |=> !out_strobe);

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ns

module datapath (
    input  logic               clock,
    input  logic               reset,
    input  logic               write_acc,
    input  logic               clear_acc,
    input  logic               write_carry,
    input  logic               clear_carry,
    input  logic               write_reg,
    input  ctrl_pkg::alu_op_t  alu_op,
    input  ctrl_pkg::alu_in0_t alu_in0,
    input  ctrl_pkg::alu_in1_t alu_in1,
    input  ctrl_pkg::alu_cin_t alu_cin,
    input  ctrl_pkg::acc_in_t  acc_in,
    input  ctrl_pkg::reg_in_t  reg_in,
    input  logic [3:0]         reg_index,
    input  isa_pkg::nibble_t   imm,
    input  isa_pkg::nibble_t   data,
    output isa_pkg::nibble_t   acc,
    output logic [7:0]         pair_value
);

    isa_pkg::nibble_t regs [isa_pkg::NUM_REGS];
    isa_pkg::nibble_t reg_val;
    isa_pkg::nibble_t in0;
    isa_pkg::nibble_t in1;
    isa_pkg::nibble_t alu_result;
    isa_pkg::nibble_t acc_next;
    isa_pkg::nibble_t reg_next;
    logic carry;
    logic cin;
    logic alu_cout;

    assign reg_val = regs[reg_index];
    assign pair_value = {regs[{reg_index[3:1], 1'b0}], regs[{reg_index[3:1], 1'b1}]};

    // operand and carry-in muxes
    always_comb begin
        case (alu_in0)
            ctrl_pkg::IN0_REG:     in0 = reg_val;
            ctrl_pkg::IN0_REG_INV: in0 = ~reg_val;
            ctrl_pkg::IN0_ACC:     in0 = acc;
            default:               in0 = ~acc;
        endcase
        case (alu_in1)
            ctrl_pkg::IN1_ACC:     in1 = acc;
            ctrl_pkg::IN1_ONE:     in1 = 4'h1;
            ctrl_pkg::IN1_ONE_INV: in1 = 4'he;
            default:               in1 = 4'h0;
        endcase
        case (alu_cin)
            ctrl_pkg::CIN_ZERO:  cin = 1'b0;
            ctrl_pkg::CIN_ONE:   cin = 1'b1;
            ctrl_pkg::CIN_CARRY: cin = carry;
            default:             cin = ~carry;
        endcase
    end

    alu alu_i (
        .in0    (in0),
        .in1    (in1),
        .cin    (cin),
        .op     (alu_op),
        .result (alu_result),
        .cout   (alu_cout)
    );

    always_comb begin
        case (acc_in)
            ctrl_pkg::ACC_FROM_ALU: acc_next = alu_result;
            ctrl_pkg::ACC_FROM_REG: acc_next = reg_val;
            ctrl_pkg::ACC_FROM_IMM: acc_next = imm;
            default:                acc_next = {3'b000, carry};
        endcase
        case (reg_in)
            ctrl_pkg::REG_FROM_ALU: reg_next = alu_result;
            ctrl_pkg::REG_FROM_ACC: reg_next = acc;
            default:                reg_next = data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_reg) begin
            regs[reg_index] <= reg_next;
        end
    end

    // a clear wins over a write, TCC reads the old carry
    always_ff @(posedge clock) begin
        if (reset) begin
            acc <= '0;
            carry <= 1'b0;
        end else begin
            if (clear_acc) begin
                acc <= '0;
            end else if (write_acc) begin
                acc <= acc_next;
            end
            if (clear_carry) begin
                carry <= 1'b0;
            end else if (write_carry) begin
                carry <= alu_cout;
            end
        end
    end

    reg_index_a: assert property (@(posedge clock) disable iff (reset)
        write_reg |-> !$isunknown(reg_index) && int'(reg_index) < isa_pkg::NUM_REGS);

endmodule

// File: hdl/instruction_decoder.sv
`timescale 1ns/1ns

module instruction_decoder (
    input  logic [7:0]          inst,
    input  isa_pkg::phase_t     phase,
    input  logic                second_word,
    output logic                pc_write,
    output logic                write_acc,
    output logic                clear_acc,
    output logic                write_carry,
    output logic                clear_carry,
    output logic                write_reg,
    output ctrl_pkg::alu_op_t   alu_op,
    output ctrl_pkg::alu_in0_t  alu_in0,
    output ctrl_pkg::alu_in1_t  alu_in1,
    output ctrl_pkg::alu_cin_t  alu_cin,
    output ctrl_pkg::acc_in_t   acc_in,
    output ctrl_pkg::reg_in_t   reg_in,
    output logic [3:0]          reg_index,
    output logic                addr_load,
    output logic                wrm
);

    isa_pkg::opcode_t opcode;
    isa_pkg::acc_sub_t acc_sub;
    isa_pkg::io_sub_t io_sub;

    assign opcode = isa_pkg::opcode_t'(inst[7:4]);
    assign acc_sub = isa_pkg::acc_sub_t'(inst[3:0]);
    assign io_sub = isa_pkg::io_sub_t'(inst[3:0]);

    always_comb begin
        pc_write = 1'b0;
        write_acc = 1'b0;
        clear_acc = 1'b0;
        write_carry = 1'b0;
        clear_carry = 1'b0;
        write_reg = 1'b0;
        alu_op = ctrl_pkg::ALU_OP_ADD;
        alu_in0 = ctrl_pkg::IN0_REG;
        alu_in1 = ctrl_pkg::IN1_ACC;
        alu_cin = ctrl_pkg::CIN_ZERO;
        acc_in = ctrl_pkg::ACC_FROM_ALU;
        reg_in = ctrl_pkg::REG_FROM_ALU;
        reg_index = inst[3:0];
        addr_load = 1'b0;
        wrm = 1'b0;

        if (second_word) begin
            case (opcode)
                isa_pkg::OP_FIM_SRC: begin
                    // even register takes the high nibble, odd the low one
                    if (phase == isa_pkg::PH_FETCH_HI || phase == isa_pkg::PH_FETCH_LO) begin
                        reg_in = ctrl_pkg::REG_FROM_DATA;
                        write_reg = 1'b1;
                        reg_index = {inst[3:1], phase == isa_pkg::PH_FETCH_LO};
                    end
                end
                isa_pkg::OP_JUN: begin
                    pc_write = (phase == isa_pkg::PH_EXEC);
                end
                default: begin
                end
            endcase
        end else if (phase == isa_pkg::PH_EXEC) begin
            case (opcode)
                isa_pkg::OP_FIM_SRC: begin
                    // SRC only, FIM does its work in the second word
                    addr_load = inst[0];
                end
                isa_pkg::OP_INC: begin
                    alu_in1 = ctrl_pkg::IN1_ONE;
                    write_reg = 1'b1;
                end
                isa_pkg::OP_ADD: begin
                    alu_cin = ctrl_pkg::CIN_CARRY;
                    write_acc = 1'b1;
                    write_carry = 1'b1;
                end
                isa_pkg::OP_SUB: begin
                    // acc + ~reg + ~borrow
                    alu_in0 = ctrl_pkg::IN0_REG_INV;
                    alu_cin = ctrl_pkg::CIN_CARRY_INV;
                    write_acc = 1'b1;
                    write_carry = 1'b1;
                end
                isa_pkg::OP_LD: begin
                    acc_in = ctrl_pkg::ACC_FROM_REG;
                    write_acc = 1'b1;
                end
                isa_pkg::OP_XCH: begin
                    acc_in = ctrl_pkg::ACC_FROM_REG;
                    reg_in = ctrl_pkg::REG_FROM_ACC;
                    write_acc = 1'b1;
                    write_reg = 1'b1;
                end
                isa_pkg::OP_LDM: begin
                    acc_in = ctrl_pkg::ACC_FROM_IMM;
                    write_acc = 1'b1;
                end
                isa_pkg::OP_IO: begin
                    wrm = (io_sub == isa_pkg::IO_WRM);
                end
                isa_pkg::OP_ACC_GRP: begin
                    alu_in0 = ctrl_pkg::IN0_ACC;
                    case (acc_sub)
                        isa_pkg::CLB: begin
                            clear_acc = 1'b1;
                            clear_carry = 1'b1;
                        end
                        isa_pkg::CLC: clear_carry = 1'b1;
                        isa_pkg::IAC: begin
                            alu_in1 = ctrl_pkg::IN1_ONE;
                            write_acc = 1'b1;
                            write_carry = 1'b1;
                        end
                        isa_pkg::CMC: begin
                            alu_op = ctrl_pkg::ALU_OP_PASS;
                            alu_cin = ctrl_pkg::CIN_CARRY_INV;
                            write_carry = 1'b1;
                        end
                        isa_pkg::CMA: begin
                            alu_op = ctrl_pkg::ALU_OP_PASS;
                            alu_in0 = ctrl_pkg::IN0_ACC_INV;
                            write_acc = 1'b1;
                        end
                        isa_pkg::RAL, isa_pkg::RAR: begin
                            alu_op = (acc_sub == isa_pkg::RAL) ? ctrl_pkg::ALU_OP_ROL
                                                               : ctrl_pkg::ALU_OP_ROR;
                            alu_cin = ctrl_pkg::CIN_CARRY;
                            write_acc = 1'b1;
                            write_carry = 1'b1;
                        end
                        isa_pkg::TCC: begin
                            acc_in = ctrl_pkg::ACC_FROM_CARRY;
                            write_acc = 1'b1;
                            clear_carry = 1'b1;
                        end
                        isa_pkg::DAC: begin
                            // acc + 4'he + 1, carry set when no borrow
                            alu_in1 = ctrl_pkg::IN1_ONE_INV;
                            alu_cin = ctrl_pkg::CIN_ONE;
                            write_acc = 1'b1;
                            write_carry = 1'b1;
                        end
                        isa_pkg::STC: begin
                            alu_op = ctrl_pkg::ALU_OP_PASS;
                            alu_cin = ctrl_pkg::CIN_ONE;
                            write_carry = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
                // NOP, first word of JUN and unknown codes
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter isa_pkg::pc_t RESET_PC = '0
) (
    input  logic             clock,
    input  logic             reset,
    input  isa_pkg::nibble_t data,
    input  logic             pc_write,
    output isa_pkg::pc_t     rom_addr,
    output logic             sync,
    output isa_pkg::phase_t  phase,
    output logic [7:0]       inst,
    output logic             second_word,
    output logic [7:0]       second_data
);

    isa_pkg::opcode_t opcode;
    logic two_word_op;
    logic jun_second;

    assign opcode = isa_pkg::opcode_t'(inst[7:4]);

    // FIM has a clear low bit, SRC shares the opcode with it set
    assign two_word_op = (opcode == isa_pkg::OP_FIM_SRC && !inst[0])
                      || (opcode == isa_pkg::OP_JUN);

    // the jump target replaces the usual increment
    assign jun_second = second_word && opcode == isa_pkg::OP_JUN;

    assign sync = (phase != isa_pkg::PH_X3);

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= isa_pkg::PH_ADDR0;
            second_word <= 1'b0;
        end else begin
            phase <= isa_pkg::phase_t'(phase + 3'd1);
            if (phase == isa_pkg::PH_X3) begin
                second_word <= !second_word && two_word_op;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            inst <= 8'h00;
        end else if (!second_word) begin
            if (phase == isa_pkg::PH_FETCH_HI) begin
                inst[7:4] <= data;
            end else if (phase == isa_pkg::PH_FETCH_LO) begin
                inst[3:0] <= data;
            end
        end
    end

    // second word bytes, kept for the jump target
    always_ff @(posedge clock) begin
        if (second_word && phase == isa_pkg::PH_FETCH_HI) begin
            second_data[7:4] <= data;
        end
        if (second_word && phase == isa_pkg::PH_FETCH_LO) begin
            second_data[3:0] <= data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rom_addr <= RESET_PC;
        end else if (pc_write) begin
            rom_addr <= {inst[3:0], second_data};
        end else if (phase == isa_pkg::PH_X3 && !jun_second) begin
            rom_addr <= rom_addr + 12'd1;
        end
    end

    // the first word must hold for the whole second cycle
    inst_held_a: assert property (@(posedge clock) disable iff (reset)
        second_word |=> $stable(inst));

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ns

module alu (
    input  isa_pkg::nibble_t  in0,
    input  isa_pkg::nibble_t  in1,
    input  logic              cin,
    input  ctrl_pkg::alu_op_t op,
    output isa_pkg::nibble_t  result,
    output logic              cout
);

    logic [4:0] sum;

    assign sum = {1'b0, in0} + {1'b0, in1} + {4'b0000, cin};

    always_comb begin
        case (op)
            ctrl_pkg::ALU_OP_ADD: begin
                result = sum[3:0];
                cout = sum[4];
            end
            // rotates go through the carry
            ctrl_pkg::ALU_OP_ROL: begin
                result = {in0[2:0], cin};
                cout = in0[3];
            end
            ctrl_pkg::ALU_OP_ROR: begin
                result = {cin, in0[3:1]};
                cout = in0[0];
            end
            default: begin
                result = in0;
                cout = cin;
            end
        endcase
    end

endmodule

// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [1:0] {
        ALU_OP_ADD,
        ALU_OP_PASS,
        ALU_OP_ROL,
        ALU_OP_ROR
    } alu_op_t;

    // first alu operand
    typedef enum logic [1:0] {
        IN0_REG,
        IN0_REG_INV,
        IN0_ACC,
        IN0_ACC_INV
    } alu_in0_t;

    // second alu operand
    typedef enum logic [1:0] {
        IN1_ACC,
        IN1_ONE,
        IN1_ONE_INV,
        IN1_ZERO
    } alu_in1_t;

    typedef enum logic [1:0] {
        CIN_ZERO,
        CIN_ONE,
        CIN_CARRY,
        CIN_CARRY_INV
    } alu_cin_t;

    typedef enum logic [1:0] {
        ACC_FROM_ALU,
        ACC_FROM_REG,
        ACC_FROM_IMM,
        ACC_FROM_CARRY
    } acc_in_t;

    typedef enum logic [1:0] {
        REG_FROM_ALU,
        REG_FROM_ACC,
        REG_FROM_DATA
    } reg_in_t;

endpackage

// File: hdl/isa_pkg.sv
package isa_pkg;

    typedef logic [3:0] nibble_t;
    typedef logic [11:0] pc_t;

    localparam int NUM_REGS = 16;

    // upper instruction nibble
    typedef enum logic [3:0] {
        OP_NOP     = 4'h0,
        OP_FIM_SRC = 4'h2,
        OP_JUN     = 4'h4,
        OP_INC     = 4'h6,
        OP_ADD     = 4'h8,
        OP_SUB     = 4'h9,
        OP_LD      = 4'ha,
        OP_XCH     = 4'hb,
        OP_LDM     = 4'hd,
        OP_IO      = 4'he,
        OP_ACC_GRP = 4'hf
    } opcode_t;

    // lower nibble inside the accumulator group
    typedef enum logic [3:0] {
        CLB = 4'h0,
        CLC = 4'h1,
        IAC = 4'h2,
        CMC = 4'h3,
        CMA = 4'h4,
        RAL = 4'h5,
        RAR = 4'h6,
        TCC = 4'h7,
        DAC = 4'h8,
        STC = 4'ha
    } acc_sub_t;

    typedef enum logic [3:0] {
        IO_WRM = 4'h0
    } io_sub_t;

    // eight clocks of one machine cycle
    typedef enum logic [2:0] {
        PH_ADDR0,
        PH_ADDR1,
        PH_ADDR2,
        PH_FETCH_HI,
        PH_FETCH_LO,
        PH_EXEC,
        PH_X2,
        PH_X3
    } phase_t;

endpackage
